/* l1_pkg.sv */
package l1_pkg;

    // Address split is tag | index | byte offset
    localparam int unsigned addr_w    = 32;
    localparam int unsigned data_w    = 32;
    localparam int unsigned index_w   = 6;    // Address bits 7:2
    localparam int unsigned tag_w     = 24;   // Address bits 31:8
    localparam int unsigned offset_w  = 2;    // Byte within the word
    localparam int unsigned num_lines = 64;

    // RISC-V major opcodes
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;

    // funct3 size codes, bit 2 selects zero extension on loads
    typedef enum logic [2:0] {
        mask_bs = 3'b000,   // Byte signed
        mask_hs = 3'b001,   // Halfword signed
        mask_w  = 3'b010,   // Word
        mask_bu = 3'b100,   // Byte unsigned
        mask_hu = 3'b101    // Halfword unsigned
    } mask_t;

    typedef enum logic [1:0] {
        mesi_i = 2'b00,
        mesi_e = 2'b01,
        mesi_s = 2'b10,
        mesi_m = 2'b11
    } mesi_t;

    // Shared bus commands, bus_none when idle
    typedef enum logic [1:0] {
        bus_rd   = 2'b00,
        bus_upgr = 2'b01,
        bus_rdx  = 2'b10,
        bus_none = 2'b11
    } bus_op_t;

    typedef struct packed {
        mesi_t              state;
        logic [tag_w-1:0]   tag;
        logic [data_w-1:0]  data;
    } line_t;

endpackage

/* l1_line_store.sv */
`timescale 1ns/1ns

module l1_line_store (
    input  logic                         clk,
    input  logic                         reset,

    // Core side read
    input  logic [l1_pkg::index_w-1:0]   core_index,
    output l1_pkg::line_t                core_line,

    // Snoop side read
    input  logic [l1_pkg::index_w-1:0]   snoop_index,
    output l1_pkg::line_t                snoop_line,

    // Write requests from both controllers
    input  logic                         core_wr,
    input  logic [l1_pkg::index_w-1:0]   core_wr_index,
    input  l1_pkg::line_t                core_wr_line,
    input  logic                         snoop_wr,
    input  logic [l1_pkg::index_w-1:0]   snoop_wr_index,
    input  l1_pkg::line_t                snoop_wr_line
);

    l1_pkg::line_t lines [l1_pkg::num_lines];

    // Both read ports are asynchronous
    assign core_line  = lines[core_index];
    assign snoop_line = lines[snoop_index];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < l1_pkg::num_lines; i++) begin
                lines[i].state <= l1_pkg::mesi_i;  // Tag and data left as they are
            end
        end else begin
            // One write per clock, core first
            if (core_wr) begin
                lines[core_wr_index] <= core_wr_line;
            end else if (snoop_wr) begin
                lines[snoop_wr_index] <= snoop_wr_line;
            end
        end
    end

endmodule

/* l1_load_align.sv */
`timescale 1ns/1ns

module l1_load_align (
    input  logic [l1_pkg::data_w-1:0]    word,
    input  l1_pkg::mask_t                mask,
    input  logic [l1_pkg::offset_w-1:0]  offset,
    output logic [l1_pkg::data_w-1:0]    load_data
);

    logic [l1_pkg::data_w-1:0] byte_lane;   // Addressed byte moved to bits 7:0
    logic [l1_pkg::data_w-1:0] half_lane;   // Addressed halfword moved to bits 15:0

    // Halfwords use only the upper offset bit
    assign byte_lane = word >> {offset, 3'b000};
    assign half_lane = word >> {offset[1], 4'b0000};

    always_comb begin
        case (mask)
            l1_pkg::mask_bs: begin
                load_data = {{(l1_pkg::data_w-8){byte_lane[7]}}, byte_lane[7:0]};
            end
            l1_pkg::mask_hs: begin
                load_data = {{(l1_pkg::data_w-16){half_lane[15]}}, half_lane[15:0]};
            end
            l1_pkg::mask_w: begin
                load_data = word;
            end
            l1_pkg::mask_bu: begin
                load_data = {{(l1_pkg::data_w-8){1'b0}}, byte_lane[7:0]};
            end
            l1_pkg::mask_hu: begin
                load_data = {{(l1_pkg::data_w-16){1'b0}}, half_lane[15:0]};
            end
            default: begin
                load_data = '0;     // Unused size codes
            end
        endcase
    end

endmodule

/* l1_store_merge.sv */
`timescale 1ns/1ns

module l1_store_merge (
    input  logic [l1_pkg::data_w-1:0]    old_word,
    input  logic [l1_pkg::data_w-1:0]    store_data,
    input  l1_pkg::mask_t                mask,
    input  logic [l1_pkg::offset_w-1:0]  offset,
    output logic [l1_pkg::data_w-1:0]    merged
);

    logic [4:0]                byte_shift;
    logic [4:0]                half_shift;
    logic [l1_pkg::data_w-1:0] byte_lanes;  // Ones over the addressed byte
    logic [l1_pkg::data_w-1:0] half_lanes;  // Ones over the addressed halfword
    logic [l1_pkg::data_w-1:0] byte_bits;
    logic [l1_pkg::data_w-1:0] half_bits;

    assign byte_shift = {offset, 3'b000};
    assign half_shift = {offset[1], 4'b0000};

    assign byte_lanes = {{(l1_pkg::data_w-8){1'b0}}, 8'hff} << byte_shift;
    assign half_lanes = {{(l1_pkg::data_w-16){1'b0}}, 16'hffff} << half_shift;
    assign byte_bits  = {{(l1_pkg::data_w-8){1'b0}}, store_data[7:0]} << byte_shift;
    assign half_bits  = {{(l1_pkg::data_w-16){1'b0}}, store_data[15:0]} << half_shift;

    // Sign of the size code plays no part in a store
    always_comb begin
        case (mask)
            l1_pkg::mask_bs, l1_pkg::mask_bu: begin
                merged = (old_word & ~byte_lanes) | byte_bits;
            end
            l1_pkg::mask_hs, l1_pkg::mask_hu: begin
                merged = (old_word & ~half_lanes) | half_bits;
            end
            l1_pkg::mask_w: begin
                merged = store_data;
            end
            default: begin
                merged = old_word;
            end
        endcase
    end

endmodule

/* l1_core_ctrl.sv */
`timescale 1ns/1ns

module l1_core_ctrl (
    input  logic                         clk,
    input  logic                         reset,

    // Core request
    input  logic [6:0]                   opcode_in,
    input  l1_pkg::mask_t                mask_in,
    input  logic [l1_pkg::addr_w-1:0]    address_in,
    input  logic [l1_pkg::data_w-1:0]    data_in,

    // Bus arbiter and fill data
    input  logic                         grant,
    input  logic                         cache_hit_in,
    input  logic [l1_pkg::data_w-1:0]    bus_data_in,

    // Line store and datapath
    output logic [l1_pkg::index_w-1:0]   core_index,
    input  l1_pkg::line_t                core_line,
    input  logic [l1_pkg::data_w-1:0]    merged,
    input  logic [l1_pkg::data_w-1:0]    load_data,
    output logic [l1_pkg::data_w-1:0]    old_word,
    output logic                         core_wr,
    output logic [l1_pkg::index_w-1:0]   core_wr_index,
    output l1_pkg::line_t                core_wr_line,

    output logic [l1_pkg::data_w-1:0]    data_out,
    output logic                         stall,
    output logic                         req_core,
    output l1_pkg::bus_op_t              bus_operation_out,
    output logic [l1_pkg::addr_w-1:0]    bus_address_out,
    output logic [l1_pkg::data_w-1:0]    data_to_l2
);

    typedef enum logic {st_main, st_fill} state_t;

    state_t                   state;
    state_t                   state_next;
    logic                     fill_shared;        // Another cache answered our BusRd
    logic                     fill_shared_next;
    logic [l1_pkg::tag_w-1:0] tag_in;
    logic                     mask_ok;
    logic                     is_load;
    logic                     is_store;
    logic                     hit;
    l1_pkg::mesi_t            line_state;         // Invalid when the tag differs

    assign tag_in     = address_in[l1_pkg::addr_w-1:l1_pkg::index_w+l1_pkg::offset_w];
    assign core_index = address_in[l1_pkg::index_w+l1_pkg::offset_w-1:l1_pkg::offset_w];
    assign core_wr_index = core_index;

    assign hit        = core_line.state != l1_pkg::mesi_i && core_line.tag == tag_in;
    assign line_state = hit ? core_line.state : l1_pkg::mesi_i;
    assign old_word   = hit ? core_line.data : '0;

    // An unsupported size code is not a request
    always_comb begin
        case (mask_in)
            l1_pkg::mask_bs, l1_pkg::mask_hs, l1_pkg::mask_w,
            l1_pkg::mask_bu, l1_pkg::mask_hu: mask_ok = 1'b1;
            default:                          mask_ok = 1'b0;
        endcase
    end

    assign is_load  = mask_ok && opcode_in == l1_pkg::op_load;
    assign is_store = mask_ok && opcode_in == l1_pkg::op_store;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= st_main;
            fill_shared <= 1'b0;
        end else begin
            state       <= state_next;
            fill_shared <= fill_shared_next;
        end
    end

    always_comb begin
        state_next        = state;
        fill_shared_next  = fill_shared;
        stall             = 1'b0;
        req_core          = 1'b0;
        data_out          = '0;
        core_wr           = 1'b0;
        core_wr_line      = '{state: l1_pkg::mesi_m, tag: tag_in, data: merged};
        bus_operation_out = l1_pkg::bus_none;
        bus_address_out   = '0;
        data_to_l2        = '0;
        case (state)
            st_main: begin
                if (is_load && hit) begin
                    data_out = load_data;           // Hit, no state change
                end else if (is_load) begin
                    stall    = 1'b1;
                    req_core = 1'b1;
                    if (grant) begin
                        bus_operation_out = l1_pkg::bus_rd;
                        bus_address_out   = address_in;
                        fill_shared_next  = cache_hit_in;
                        state_next        = st_fill;
                    end
                end else if (is_store) begin
                    req_core = 1'b1;
                    stall    = !grant;
                    if (grant) begin
                        // E and M write silently
                        case (line_state)
                            l1_pkg::mesi_s: begin
                                bus_operation_out = l1_pkg::bus_upgr;
                                bus_address_out   = address_in;
                            end
                            l1_pkg::mesi_i: begin
                                bus_operation_out = l1_pkg::bus_rdx;
                                bus_address_out   = address_in;
                            end
                            default: begin
                                bus_operation_out = l1_pkg::bus_none;
                            end
                        endcase
                        data_to_l2 = merged;
                        core_wr    = 1'b1;          // Line goes to M
                    end
                end
            end
            st_fill: begin
                // Bus word lands unmerged
                stall        = 1'b1;
                core_wr      = 1'b1;
                core_wr_line = '{state: fill_shared ? l1_pkg::mesi_s : l1_pkg::mesi_e,
                                 tag: tag_in, data: bus_data_in};
                state_next   = st_main;
            end
            default: begin
                state_next = st_main;
            end
        endcase
    end

endmodule

/* l1_snoop_ctrl.sv */
`timescale 1ns/1ns

module l1_snoop_ctrl (
    // Snooped bus traffic
    input  l1_pkg::bus_op_t              bus_operation_in,
    input  logic [l1_pkg::addr_w-1:0]    bus_address_in,

    // Line store
    output logic [l1_pkg::index_w-1:0]   snoop_index,
    input  l1_pkg::line_t                snoop_line,
    output logic                         snoop_wr,
    output logic [l1_pkg::index_w-1:0]   snoop_wr_index,
    output l1_pkg::line_t                snoop_wr_line,

    // Response to the bus
    output logic [l1_pkg::data_w-1:0]    bus_data_out,
    output logic                         cache_hit_out,
    output logic                         flush_out
);

    logic                     tag_hit;    // Valid line with the snooped tag
    logic                     read_op;    // BusRd or BusRdX
    logic [l1_pkg::tag_w-1:0] snoop_tag;

    assign snoop_index =
        bus_address_in[l1_pkg::index_w+l1_pkg::offset_w-1:l1_pkg::offset_w];
    assign snoop_tag   = bus_address_in[l1_pkg::addr_w-1:l1_pkg::index_w+l1_pkg::offset_w];

    assign tag_hit = bus_operation_in != l1_pkg::bus_none &&
                     snoop_line.state != l1_pkg::mesi_i &&
                     snoop_line.tag == snoop_tag;

    assign read_op = bus_operation_in == l1_pkg::bus_rd ||
                     bus_operation_in == l1_pkg::bus_rdx;

    // BusUpgr only invalidates, it gets no data
    assign cache_hit_out = tag_hit && read_op;
    assign bus_data_out  = cache_hit_out ? snoop_line.data : '0;
    assign flush_out     = tag_hit && snoop_line.state == l1_pkg::mesi_m;

    assign snoop_wr       = tag_hit;
    assign snoop_wr_index = snoop_index;

    // Same tag and data, new state only
    always_comb begin
        snoop_wr_line = snoop_line;
        if (bus_operation_in == l1_pkg::bus_rd) begin
            snoop_wr_line.state = l1_pkg::mesi_s;
        end else begin
            snoop_wr_line.state = l1_pkg::mesi_i;   // BusUpgr, BusRdX
        end
    end

endmodule

/* l1_cache_top.sv */
`timescale 1ns/1ns

module l1_cache_top (
    input  logic                         clk,
    input  logic                         reset,

    // Core side
    input  logic [6:0]                   opcode_in,
    input  l1_pkg::mask_t                mask_in,
    input  logic [l1_pkg::addr_w-1:0]    address_in,
    input  logic [l1_pkg::data_w-1:0]    data_in,
    output logic [l1_pkg::data_w-1:0]    data_out,
    output logic                         stall,
    output logic                         req_core,

    // Shared bus, own requests
    input  logic                         grant,
    input  logic                         cache_hit_in,
    input  logic [l1_pkg::data_w-1:0]    bus_data_in,
    output l1_pkg::bus_op_t              bus_operation_out,
    output logic [l1_pkg::addr_w-1:0]    bus_address_out,
    output logic [l1_pkg::data_w-1:0]    data_to_l2,

    // Shared bus, snooping
    input  l1_pkg::bus_op_t              bus_operation_in,
    input  logic [l1_pkg::addr_w-1:0]    bus_address_in,
    output logic [l1_pkg::data_w-1:0]    bus_data_out,
    output logic                         cache_hit_out,
    output logic                         flush_out
);

    logic [l1_pkg::index_w-1:0] core_index;
    l1_pkg::line_t              core_line;
    logic [l1_pkg::index_w-1:0] snoop_index;
    l1_pkg::line_t              snoop_line;
    logic                       core_wr;
    logic [l1_pkg::index_w-1:0] core_wr_index;
    l1_pkg::line_t              core_wr_line;
    logic                       snoop_wr;
    logic [l1_pkg::index_w-1:0] snoop_wr_index;
    l1_pkg::line_t              snoop_wr_line;
    logic [l1_pkg::data_w-1:0]  old_word;     // Zero on a tag miss
    logic [l1_pkg::data_w-1:0]  merged;
    logic [l1_pkg::data_w-1:0]  load_data;

    l1_line_store l1_line_store_i (
        .clk, .reset,
        .core_index, .core_line,
        .snoop_index, .snoop_line,
        .core_wr, .core_wr_index, .core_wr_line,
        .snoop_wr, .snoop_wr_index, .snoop_wr_line
    );

    l1_load_align l1_load_align_i (
        .word      (old_word),
        .mask      (mask_in),
        .offset    (address_in[l1_pkg::offset_w-1:0]),
        .load_data (load_data)
    );

    l1_store_merge l1_store_merge_i (
        .old_word   (old_word),
        .store_data (data_in),
        .mask       (mask_in),
        .offset     (address_in[l1_pkg::offset_w-1:0]),
        .merged     (merged)
    );

    l1_core_ctrl l1_core_ctrl_i (
        .clk, .reset,
        .opcode_in, .mask_in, .address_in, .data_in,
        .grant, .cache_hit_in, .bus_data_in,
        .core_index, .core_line, .merged, .load_data, .old_word,
        .core_wr, .core_wr_index, .core_wr_line,
        .data_out, .stall, .req_core,
        .bus_operation_out, .bus_address_out, .data_to_l2
    );

    l1_snoop_ctrl l1_snoop_ctrl_i (
        .bus_operation_in, .bus_address_in,
        .snoop_index, .snoop_line,
        .snoop_wr, .snoop_wr_index, .snoop_wr_line,
        .bus_data_out, .cache_hit_out, .flush_out
    );

endmodule

/* l1_cache_model.svh */
`ifndef L1_CACHE_MODEL_SVH
`define L1_CACHE_MODEL_SVH

// Mirror of all 64 lines kept in step with every access
logic [1:0]  model_state [64];
logic [23:0] model_tag   [64];
logic [31:0] model_data  [64];
logic [31:0] lfsr_state = 32'hc459;

// Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        r = {r[30:0], fb};
    end
    return r;
endfunction

// State of the line if the tag matches and invalid otherwise
function automatic logic [1:0] line_state(input logic [5:0] idx, input logic [23:0] tag);
    if (model_tag[idx] == tag) begin
        return model_state[idx];
    end
    return l1_pkg::mesi_i;
endfunction

// Bit 2 of funct3 zero-extends and halfwords use offset bit 1
function automatic logic [31:0] align_load(input logic [31:0] word, input logic [2:0] mask,
                                           input logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[off*8 +: 8];
    h = off[1] ? word[31:16] : word[15:0];
    case (mask)
        3'b000:  return {{24{b[7]}}, b};
        3'b001:  return {{16{h[15]}}, h};
        3'b010:  return word;
        3'b100:  return {24'h0, b};
        3'b101:  return {16'h0, h};
        default: return '0;
    endcase
endfunction

function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [31:0] data,
                                            input logic [2:0] mask, input logic [1:0] off);
    logic [31:0] r;
    r = old;
    case (mask)
        3'b000, 3'b100: r[off*8 +: 8] = data[7:0];
        3'b001, 3'b101: r[off[1]*16 +: 16] = data[15:0];
        3'b010:         r = data;
        default:        r = old;
    endcase
    return r;
endfunction

// Bus command a store issues from each state
function automatic logic [1:0] store_bus_op(input logic [1:0] st);
    if (st == l1_pkg::mesi_s) return l1_pkg::bus_upgr;
    if (st == l1_pkg::mesi_i) return l1_pkg::bus_rdx;
    return l1_pkg::bus_none;
endfunction

`endif

/* l1_cache_tb.sv */
`timescale 1ns/1ns

module l1_cache_tb;

    logic              clk;
    logic              reset;
    logic [6:0]        opcode_in;
    l1_pkg::mask_t     mask_in;
    logic [31:0]       address_in;
    logic [31:0]       data_in;
    logic [31:0]       data_out;
    logic              stall;
    logic              req_core;
    logic              grant;
    logic              cache_hit_in;
    logic [31:0]       bus_data_in;
    l1_pkg::bus_op_t   bus_operation_out;
    logic [31:0]       bus_address_out;
    logic [31:0]       data_to_l2;
    l1_pkg::bus_op_t   bus_operation_in;
    logic [31:0]       bus_address_in;
    logic [31:0]       bus_data_out;
    logic              cache_hit_out;
    logic              flush_out;

    int                errors = 0;
    int                checks = 0;
    logic              chk_valid;
    logic [31:0]       exp_stall, exp_req, exp_data_out, exp_bus_op, exp_bus_addr;
    logic [31:0]       exp_l2, exp_hit_out, exp_bus_data, exp_flush;

    `include "l1_cache_model.svh"

    l1_cache_top l1_cache_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Whole run limit
    initial begin
        #(100 * 20000);
        $display("Timeout: the run did not finish");
        $display("=== FAIL ===");
        $finish;
    end

    function automatic void exp_idle();
        exp_stall    = 0;
        exp_req      = 0;
        exp_data_out = 0;
        exp_bus_op   = l1_pkg::bus_none;
        exp_bus_addr = 0;
        exp_l2       = 0;
        exp_hit_out  = 0;
        exp_bus_data = 0;
        exp_flush    = 0;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (chk_valid) begin
            compare_value("stall", {31'b0, stall}, exp_stall);
            compare_value("req_core", {31'b0, req_core}, exp_req);
            compare_value("data_out", data_out, exp_data_out);
            compare_value("bus_operation_out", {30'b0, bus_operation_out}, exp_bus_op);
            compare_value("bus_address_out", bus_address_out, exp_bus_addr);
            compare_value("data_to_l2", data_to_l2, exp_l2);
            compare_value("cache_hit_out", {31'b0, cache_hit_out}, exp_hit_out);
            compare_value("bus_data_out", bus_data_out, exp_bus_data);
            compare_value("flush_out", {31'b0, flush_out}, exp_flush);
        end
    end

    task automatic drive_core(input logic [6:0] op, input logic [2:0] mask,
                              input logic [31:0] addr, input logic [31:0] data, input logic g);
        opcode_in        <= op;
        mask_in          <= l1_pkg::mask_t'(mask);
        address_in       <= addr;
        data_in          <= data;
        grant            <= g;
        bus_operation_in <= l1_pkg::bus_none;
        bus_address_in   <= '0;
    endtask

    task automatic load_op(input logic [2:0] mask, input logic [31:0] addr, input int grant_wait,
                           input logic hit_in, input logic [31:0] fill);
        int n;
        if (line_state(addr[7:2], addr[31:8]) != l1_pkg::mesi_i) begin
            @(posedge clk);
            drive_core(l1_pkg::op_load, mask, addr, rand_bits(32), 1'b0);
            exp_idle();
            exp_data_out = align_load(model_data[addr[7:2]], mask, addr[1:0]);
            return;
        end
        for (n = 0; n <= grant_wait && n < 32; n++) begin
            @(posedge clk);
            drive_core(l1_pkg::op_load, mask, addr, '0, n == grant_wait);
            cache_hit_in <= hit_in;
            exp_idle();
            exp_stall = 1;
            exp_req   = 1;
            if (n == grant_wait) begin
                exp_bus_op   = l1_pkg::bus_rd;
                exp_bus_addr = addr;
            end
        end
        // Fill cycle and then the hit
        n = 0;
        do begin
            @(posedge clk);
            grant        <= 1'b0;
            cache_hit_in <= 1'b0;
            bus_data_in  <= fill;
            exp_idle();
            if (n == 0) begin
                exp_stall = 1;
                model_state[addr[7:2]] = hit_in ? l1_pkg::mesi_s : l1_pkg::mesi_e;
                model_tag[addr[7:2]]   = addr[31:8];
                model_data[addr[7:2]]  = fill;
            end else begin
                exp_data_out = align_load(fill, mask, addr[1:0]);
            end
            @(negedge clk);
            n++;
        end while (stall && n < 8);
        if (stall) begin
            errors++;
            $display("Timeout: stall stayed high after the fill of address %h", addr);
        end
    endtask

    task automatic store_op(input logic [2:0] mask, input logic [31:0] addr,
                            input logic [31:0] data, input int grant_wait);
        logic [1:0]  st;
        logic [31:0] old;
        for (int n = 0; n <= grant_wait && n < 32; n++) begin
            @(posedge clk);
            drive_core(l1_pkg::op_store, mask, addr, data, n == grant_wait);
            exp_idle();
            exp_req = 1;
            if (n < grant_wait) begin
                exp_stall = 1;
            end else begin
                st  = line_state(addr[7:2], addr[31:8]);
                old = (st != l1_pkg::mesi_i) ? model_data[addr[7:2]] : 32'h0;
                exp_bus_op   = store_bus_op(st);
                exp_bus_addr = (exp_bus_op != l1_pkg::bus_none) ? addr : 32'h0;
                exp_l2       = merge_store(old, data, mask, addr[1:0]);
                model_state[addr[7:2]] = l1_pkg::mesi_m;
                model_tag[addr[7:2]]   = addr[31:8];
                model_data[addr[7:2]]  = exp_l2;
            end
        end
    endtask

    task automatic snoop_op(input l1_pkg::bus_op_t op, input logic [31:0] addr);
        logic [1:0] st;
        @(posedge clk);
        opcode_in        <= '0;       // Core idle
        grant            <= 1'b0;
        bus_operation_in <= op;
        bus_address_in   <= addr;
        exp_idle();
        st = line_state(addr[7:2], addr[31:8]);
        if (st != l1_pkg::mesi_i) begin
            exp_hit_out  = (op == l1_pkg::bus_rd || op == l1_pkg::bus_rdx);
            exp_bus_data = exp_hit_out ? model_data[addr[7:2]] : 32'h0;
            exp_flush    = (st == l1_pkg::mesi_m);
            model_state[addr[7:2]] = (op == l1_pkg::bus_rd) ? l1_pkg::mesi_s : l1_pkg::mesi_i;
        end
    endtask

    function automatic logic [2:0] mask_pick(input logic [2:0] r);
        case (r % 5)
            0:       return 3'b000;
            1:       return 3'b001;
            2:       return 3'b010;
            3:       return 3'b100;
            default: return 3'b101;
        endcase
    endfunction

    initial begin
        logic [31:0] a0, a1, a2, a3, a;
        logic [23:0] rtag [2];
        logic [5:0]  idx_set [4];
        logic [1:0]  kind;
        opcode_in = '0;
        mask_in = l1_pkg::mask_w;
        address_in = '0;
        data_in = '0;
        grant = 1'b0;
        cache_hit_in = 1'b0;
        bus_data_in = '0;
        bus_operation_in = l1_pkg::bus_none;
        bus_address_in = '0;
        reset = 1'b1;
        chk_valid = 1'b0;
        exp_idle();
        for (int i = 0; i < 64; i++) begin
            model_state[i] = l1_pkg::mesi_i;
            model_tag[i]   = '0;
            model_data[i]  = '0;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        chk_valid = 1'b1;

        a0 = {24'(rand_bits(24)), 6'h05, 2'b00};
        a1 = {24'(rand_bits(24)), 6'h09, 2'b10};
        a2 = {24'(rand_bits(24)), 6'h0c, 2'b01};
        a3 = {~a0[31:8], a0[7:0]};     // Same index as a0 with another tag
        // Miss and fill in E and then every size at every offset
        load_op(3'b010, a0, 2, 1'b0, rand_bits(32));
        for (int m = 0; m < 5; m++) begin
            for (int o = 0; o < 4; o++) begin
                load_op(mask_pick(3'(m)), {a0[31:2], o[1:0]}, 0, 1'b0, '0);
            end
        end
        // Silent store to E, dirty snoop, upgrade from S
        store_op(3'b000, {a0[31:2], 2'b11}, rand_bits(32), 1);
        load_op(3'b010, a0, 0, 1'b0, '0);
        snoop_op(l1_pkg::bus_rd, a0);
        store_op(3'b101, {a0[31:2], 2'b10}, rand_bits(32), 2);
        // Shared fill
        load_op(3'b001, a1, 1, 1'b1, rand_bits(32));
        store_op(3'b010, a1, rand_bits(32), 0);
        snoop_op(l1_pkg::bus_rd, a1);
        // Stores to an invalid and a tag-mismatched line
        store_op(3'b100, a2, rand_bits(32), 1);
        store_op(3'b000, {a3[31:2], 2'b01}, rand_bits(32), 0);
        // Invalidations and a snoop with a foreign tag
        snoop_op(l1_pkg::bus_upgr, a1);
        load_op(3'b010, a1, 1, 1'b0, rand_bits(32));
        snoop_op(l1_pkg::bus_rdx, a3);
        load_op(3'b010, a3, 0, 1'b1, rand_bits(32));
        snoop_op(l1_pkg::bus_rd, a0);
        load_op(3'b010, a3, 0, 1'b0, '0);

        // Random traffic over eight addresses
        rtag[0] = 24'(rand_bits(24));
        rtag[1] = 24'(rand_bits(24));
        idx_set = '{6'h03, 6'h11, 6'h24, 6'h3e};
        for (int k = 0; k < 300; k++) begin
            a    = {rtag[rand_bits(1)], idx_set[rand_bits(2)], 2'(rand_bits(2))};
            kind = 2'(rand_bits(2));
            if (kind < 2) begin
                load_op(mask_pick(3'(rand_bits(3))), a, rand_bits(2), 1'(rand_bits(1)),
                        rand_bits(32));
            end else if (kind == 2) begin
                store_op(mask_pick(3'(rand_bits(3))), a, rand_bits(32), rand_bits(2));
            end else begin
                snoop_op(l1_pkg::bus_op_t'(rand_bits(2) % 3), a);
            end
        end

        @(posedge clk);
        drive_core('0, 3'b010, '0, '0, 1'b0);
        exp_idle();
        @(negedge clk);
        #1;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+.
l1_pkg.sv
l1_line_store.sv
l1_load_align.sv
l1_store_merge.sv
l1_core_ctrl.sv
l1_snoop_ctrl.sv
l1_cache_top.sv
l1_cache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the L1 cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module l1_cache_tb -o sim_l1
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_l1 > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error"
    exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"
exit 0
